/* common/image_cfg.svh */
`ifndef IMAGE_CFG_SVH
`define IMAGE_CFG_SVH

// Number of on-chip image memories
`define IMG_BANKS 6

// Words held by each memory
`define IMG_DEPTH 20

// Bits per pixel, two pixels per word
`define IMG_PIX_W 9

// Host link word width
`define LINK_W 32

`endif

/* common/img_pkg.sv */
`default_nettype none

`include "image_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Image storage types
////////////////////////////////////////////////////////////////////////////

package img_pkg;

	// One memory word holds a vertical pixel pair
	// Second image row sits in the upper half
	typedef struct packed {
		logic [`IMG_PIX_W-1:0] row1;
		logic [`IMG_PIX_W-1:0] row0;
	} pix_pair_t;

	// Which memory
	typedef logic [$clog2(`IMG_BANKS)-1:0] bank_idx_t;

	// Word within one memory
	typedef logic [$clog2(`IMG_DEPTH)-1:0] word_addr_t;

endpackage

`default_nettype wire

/* common/link_pkg.sv */
`default_nettype none

`include "image_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Host link and session types
////////////////////////////////////////////////////////////////////////////

package link_pkg;

	// Word on both host links, location tag on top
	typedef struct packed {
		img_pkg::bank_idx_t  bank;
		img_pkg::word_addr_t addr;
		logic [`LINK_W-$bits(img_pkg::bank_idx_t)-$bits(img_pkg::word_addr_t)
			-$bits(img_pkg::pix_pair_t)-1:0] pad;
		img_pkg::pix_pair_t  pix;
	} host_word_t;

	// Session phases, shown as-is on the state digit
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		CLEAR = 3'd1,
		LOAD  = 3'd2,
		GAP   = 3'd3,
		READ  = 3'd4,
		DONE  = 3'd5
	} session_e;

	// Three display digits
	typedef struct packed {
		logic [3:0] state_dig;
		logic [3:0] load_dig;
		logic [3:0] read_dig;
	} status_t;

endpackage

`default_nettype wire

/* verilog/image_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Banked image store
// One write port and one read port shared across all memories
////////////////////////////////////////////////////////////////////////////

module image_bank (
	input  wire logic                CLOCK_50,
	input  wire logic                wr_en,
	input  wire img_pkg::bank_idx_t  wr_bank,
	input  wire img_pkg::word_addr_t wr_addr,
	input  wire img_pkg::pix_pair_t  wr_pix,
	input  wire img_pkg::bank_idx_t  rd_bank,
	input  wire img_pkg::word_addr_t rd_addr,
	output img_pkg::pix_pair_t       rd_pix
);

	// Read location, one cycle behind the reader
	img_pkg::bank_idx_t  rd_bank_q;
	img_pkg::word_addr_t rd_addr_q;
	img_pkg::pix_pair_t  bank_q [`IMG_BANKS];

	always_ff @(posedge CLOCK_50) begin
		rd_bank_q <= rd_bank;
		rd_addr_q <= rd_addr;
	end

	for (genvar b = 0; b < `IMG_BANKS; b++) begin : g_mem
		img_pkg::pix_pair_t mem [`IMG_DEPTH];

		// Write decode, only the tagged memory sees the strobe
		always_ff @(posedge CLOCK_50) begin
			if (wr_en && (wr_bank == img_pkg::bank_idx_t'(b))) mem[wr_addr] <= wr_pix;
		end

		assign bank_q[b] = mem[rd_addr_q];
	end

	// Output select by the registered bank
	assign rd_pix = bank_q[rd_bank_q];

endmodule

`default_nettype wire

/* loader/frame_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Load side of the host link
// Four-phase receiver, each accepted word goes straight to the bank
////////////////////////////////////////////////////////////////////////////

module frame_loader (
	input  wire logic                CLOCK_50,
	input  wire logic                rst,
	input  wire logic                load_en,
	input  wire logic                host_req,
	input  wire link_pkg::host_word_t host_data,
	output logic                     load_ack,
	output logic                     wr_en,
	output img_pkg::bank_idx_t       wr_bank,
	output img_pkg::word_addr_t      wr_addr,
	output img_pkg::pix_pair_t       wr_pix,
	output logic                     load_done,
	output logic [3:0]               load_nib
);

	localparam int unsigned TOTAL = `IMG_BANKS * `IMG_DEPTH;
	localparam int unsigned CNT_W = $clog2(TOTAL + 1);

	// Accepted word count
	logic [CNT_W-1:0] word_cnt;

	// New request while idle on the link
	// Write lands on the edge that raises ack
	assign wr_en   = load_en && host_req && !load_ack && !load_done;
	assign wr_bank = host_data.bank;
	assign wr_addr = host_data.addr;
	assign wr_pix  = host_data.pix;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			load_ack <= 1'b0;
			word_cnt <= '0;
		end else if (wr_en) begin
			load_ack <= 1'b1;
			word_cnt <= word_cnt + 1'b1;
		end else if (load_ack && !host_req) begin
			// Host let go, close the cycle
			load_ack <= 1'b0;
		end
	end

	assign load_done = (word_cnt == CNT_W'(TOTAL));
	// Low nibble for the display
	assign load_nib  = word_cnt[3:0];

	// Host tag must name a real memory location
	a_tag_in_range: assert property (@(posedge CLOCK_50) disable iff (rst)
		wr_en |-> (int'(wr_bank) < `IMG_BANKS) && (int'(wr_addr) < `IMG_DEPTH));

endmodule

`default_nettype wire

/* reader/frame_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Readback side of the host link
// Bank-major scan, one tagged word per four-phase cycle
////////////////////////////////////////////////////////////////////////////

module frame_reader (
	input  wire logic                CLOCK_50,
	input  wire logic                rst,
	input  wire logic                scan_start,
	output img_pkg::bank_idx_t       rd_bank,
	output img_pkg::word_addr_t      rd_addr,
	input  wire img_pkg::pix_pair_t  rd_pix,
	output logic                     fpga_req,
	output link_pkg::host_word_t     fpga_data,
	input  wire logic                host_ack,
	output logic                     read_done,
	output logic [3:0]               read_nib
);

	localparam int unsigned TOTAL = `IMG_BANKS * `IMG_DEPTH;
	localparam int unsigned CNT_W = $clog2(TOTAL + 1);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_FETCH,
		RD_SEND,
		RD_RELEASE
	} rd_state_e;

	rd_state_e        state;
	logic [CNT_W-1:0] ack_cnt;
	logic             last_addr;
	logic             last_bank;

	assign last_addr = (rd_addr == img_pkg::word_addr_t'(`IMG_DEPTH - 1));
	assign last_bank = (rd_bank == img_pkg::bank_idx_t'(`IMG_BANKS - 1));

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state    <= RD_IDLE;
			fpga_req <= 1'b0;
			rd_bank  <= '0;
			rd_addr  <= '0;
			ack_cnt  <= '0;
		end else begin
			case (state)
				RD_IDLE: if (scan_start) state <= RD_FETCH;
				// Bank data valid here, offer the word
				RD_FETCH: begin
					fpga_req <= 1'b1;
					state    <= RD_SEND;
				end
				RD_SEND: if (host_ack) begin
					fpga_req <= 1'b0;
					ack_cnt  <= ack_cnt + 1'b1;
					// Step early so the bank has the next word by ack low
					rd_addr  <= last_addr ? '0 : rd_addr + 1'b1;
					if (last_addr) rd_bank <= last_bank ? '0 : rd_bank + 1'b1;
					state    <= RD_RELEASE;
				end
				RD_RELEASE: if (!host_ack) begin
					state <= read_done ? RD_IDLE : RD_FETCH;
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// Word plus its location, held for the whole req phase
	always_ff @(posedge CLOCK_50) begin
		if (state == RD_FETCH) begin
			fpga_data.bank <= rd_bank;
			fpga_data.addr <= rd_addr;
			fpga_data.pad  <= '0;
			fpga_data.pix  <= rd_pix;
		end
	end

	assign read_done = (ack_cnt == CNT_W'(TOTAL));
	assign read_nib  = ack_cnt[3:0];

	// Host may sample any time while req is up
	a_data_held: assert property (@(posedge CLOCK_50) disable iff (rst)
		fpga_req && $past(fpga_req) |-> $stable(fpga_data));

endmodule

`default_nettype wire

/* verilog/session_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Session sequencer
// Load phase, then readback phase, status on three digits
////////////////////////////////////////////////////////////////////////////

module session_ctrl (
	input  wire logic       CLOCK_50,
	input  wire logic       rst,
	input  wire logic       load_done,
	input  wire logic [3:0] load_nib,
	input  wire logic       read_done,
	input  wire logic [3:0] read_nib,
	output logic            load_en,
	output logic            scan_start,
	output logic [6:0]      hex0,
	output logic [6:0]      hex1,
	output logic [6:0]      hex2,
	output logic            done_led
);

	link_pkg::session_e state;
	link_pkg::status_t  status;

	// Active-low glyph, segment a in bit 0
	function automatic logic [6:0] seg_glyph(input logic [3:0] dig);
		logic [6:0] lit;
		case (dig)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state      <= link_pkg::IDLE;
			scan_start <= 1'b0;
		end else begin
			// Single-cycle start pulse
			scan_start <= 1'b0;
			case (state)
				link_pkg::IDLE:  state <= link_pkg::CLEAR;
				link_pkg::CLEAR: state <= link_pkg::LOAD;
				link_pkg::LOAD:  if (load_done) state <= link_pkg::GAP;
				link_pkg::GAP: begin
					state      <= link_pkg::READ;
					scan_start <= 1'b1;
				end
				link_pkg::READ:  if (read_done) state <= link_pkg::DONE;
				// Parked until reset
				link_pkg::DONE:  state <= link_pkg::DONE;
				default:         state <= link_pkg::IDLE;
			endcase
		end
	end

	assign load_en  = (state == link_pkg::LOAD);
	assign done_led = (state == link_pkg::DONE);

	// Status digits
	assign status.state_dig = {1'b0, state};
	assign status.load_dig  = load_nib;
	assign status.read_dig  = read_nib;

	assign hex0 = seg_glyph(status.state_dig);
	assign hex1 = seg_glyph(status.load_dig);
	assign hex2 = seg_glyph(status.read_dig);

	// Loader must be closed before the scan starts
	a_phase_excl: assert property (@(posedge CLOCK_50) disable iff (rst)
		!(load_en && scan_start));

endmodule

`default_nettype wire

/* verilog/image_seq_top.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Image buffer top level
// Loader and reader share the bank, sequencer orders the phases
////////////////////////////////////////////////////////////////////////////

module image_seq_top (
	input  wire logic                 CLOCK_50,
	input  wire logic                 rst,
	// Load link
	input  wire logic                 host_req,
	input  wire link_pkg::host_word_t host_data,
	output logic                      load_ack,
	// Read link
	output logic                      fpga_req,
	output link_pkg::host_word_t      fpga_data,
	input  wire logic                 host_ack,
	// Status
	output logic [6:0]                hex0,
	output logic [6:0]                hex1,
	output logic [6:0]                hex2,
	output logic                      done_led
);

	// Sequencer controls
	logic load_en;
	logic scan_start;

	// Write port
	logic                wr_en;
	img_pkg::bank_idx_t  wr_bank;
	img_pkg::word_addr_t wr_addr;
	img_pkg::pix_pair_t  wr_pix;

	// Read port
	img_pkg::bank_idx_t  rd_bank;
	img_pkg::word_addr_t rd_addr;
	img_pkg::pix_pair_t  rd_pix;

	// Progress back to the sequencer
	logic       load_done;
	logic       read_done;
	logic [3:0] load_nib;
	logic [3:0] read_nib;

	frame_loader u_loader (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.load_en  (load_en),
		.host_req (host_req),
		.host_data(host_data),
		.load_ack (load_ack),
		.wr_en    (wr_en),
		.wr_bank  (wr_bank),
		.wr_addr  (wr_addr),
		.wr_pix   (wr_pix),
		.load_done(load_done),
		.load_nib (load_nib)
	);

	frame_reader u_reader (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.scan_start(scan_start),
		.rd_bank   (rd_bank),
		.rd_addr   (rd_addr),
		.rd_pix    (rd_pix),
		.fpga_req  (fpga_req),
		.fpga_data (fpga_data),
		.host_ack  (host_ack),
		.read_done (read_done),
		.read_nib  (read_nib)
	);

	image_bank u_bank (
		.CLOCK_50(CLOCK_50),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_pix  (wr_pix),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_pix  (rd_pix)
	);

	session_ctrl u_session (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.load_done (load_done),
		.load_nib  (load_nib),
		.read_done (read_done),
		.read_nib  (read_nib),
		.load_en   (load_en),
		.scan_start(scan_start),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.done_led  (done_led)
	);

endmodule

`default_nettype wire

/* testbench/image_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Monitor for the image buffer
// Samples both host links and the status outputs on the falling edge
////////////////////////////////////////////////////////////////////////////

module image_checker (
	input  wire logic                 CLOCK_50,
	input  wire logic                 rst,
	input  wire logic                 host_req,
	input  wire logic                 load_ack,
	input  wire logic                 fpga_req,
	input  wire link_pkg::host_word_t fpga_data,
	input  wire logic                 host_ack,
	input  wire logic [6:0]           hex0,
	input  wire logic [6:0]           hex1,
	input  wire logic [6:0]           hex2,
	input  wire logic                 done_led,
	input  wire img_pkg::pix_pair_t   exp_pix [`IMG_BANKS*`IMG_DEPTH],
	input  wire logic                 end_req,
	output int                        val_errs,
	output int                        proto_errs,
	output logic                      checked
);

	localparam int TOTAL = `IMG_BANKS * `IMG_DEPTH;

	// Previous falling-edge samples
	logic                 p_host_req;
	logic                 p_load_ack;
	logic                 p_fpga_req;
	logic                 p_host_ack;
	link_pkg::host_word_t p_fpga_data;

	logic                 after_rst;
	int                   ld_cnt;
	int                   rd_cnt;
	link_pkg::host_word_t exp_word;

	// Standard active-low hex glyphs with segment a in bit 0
	function automatic logic [6:0] hex_glyph(input logic [3:0] d);
		logic [6:0] g;
		case (d)
			4'h0: g = 7'h40;
			4'h1: g = 7'h79;
			4'h2: g = 7'h24;
			4'h3: g = 7'h30;
			4'h4: g = 7'h19;
			4'h5: g = 7'h12;
			4'h6: g = 7'h02;
			4'h7: g = 7'h78;
			4'h8: g = 7'h00;
			4'h9: g = 7'h10;
			4'hA: g = 7'h08;
			4'hB: g = 7'h03;
			4'hC: g = 7'h46;
			4'hD: g = 7'h21;
			4'hE: g = 7'h06;
			default: g = 7'h0E;
		endcase
		return g;
	endfunction

	task automatic check_value(input string sig, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp) begin
			val_errs = val_errs + 1;
			$display("** Error at %0t ns: %s expected 'h%0h, got 'h%0h",
				$time, sig, exp, act);
		end
	endtask

	task automatic protocol_fault(input string what);
		proto_errs = proto_errs + 1;
		$display("Protocol error at %0t ns: %s", $time, what);
	endtask

	always @(negedge CLOCK_50) begin
		if (rst) begin
			ld_cnt     = 0;
			rd_cnt     = 0;
			val_errs   = 0;
			proto_errs = 0;
			checked    = 1'b0;
			after_rst  = 1'b1;
		end else begin
			// First cycle out of reset
			if (after_rst) begin
				check_value("load_ack", 32'd0, 32'(load_ack));
				check_value("fpga_req", 32'd0, 32'(fpga_req));
				check_value("done_led", 32'd0, 32'(done_led));
				if (hex0 !== hex_glyph(4'(link_pkg::IDLE)) &&
					hex0 !== hex_glyph(4'(link_pkg::CLEAR)))
					check_value("hex0", 32'(hex_glyph(4'(link_pkg::IDLE))), 32'(hex0));
				after_rst = 1'b0;
			end

			/////////////////////////////////////////////////////////////////////////
			// Four-phase receiver side of the load link
			if (load_ack && !p_load_ack) begin
				if (!p_host_req) protocol_fault("load_ack rose without host_req high");
				ld_cnt = ld_cnt + 1;
			end
			if (!load_ack && p_load_ack && p_host_req)
				protocol_fault("load_ack fell while host_req was still high");

			/////////////////////////////////////////////////////////////////////////
			// Order and content of every word on the read link
			if (fpga_req && !p_fpga_req) begin
				if (p_host_ack)
					protocol_fault("fpga_req rose while host_ack was still high");
				if (rd_cnt >= TOTAL) begin
					protocol_fault("reader sent a word past the end of the buffer");
				end else begin
					// Bank-major position gives the tag
					exp_word.bank = img_pkg::bank_idx_t'(rd_cnt / `IMG_DEPTH);
					exp_word.addr = img_pkg::word_addr_t'(rd_cnt % `IMG_DEPTH);
					exp_word.pad  = '0;
					exp_word.pix  = exp_pix[rd_cnt];
					// Read digit counts the words acked so far
					check_value("hex0", 32'(hex_glyph(4'(link_pkg::READ))), 32'(hex0));
					check_value("hex1", 32'(hex_glyph(4'(TOTAL % 16))), 32'(hex1));
					check_value("hex2", 32'(hex_glyph(4'(rd_cnt % 16))), 32'(hex2));
				end
				rd_cnt = rd_cnt + 1;
			end
			// Offered word holds for the whole req phase
			if (fpga_req && rd_cnt <= TOTAL)
				check_value("fpga_data", exp_word, fpga_data);

			// Closing state of the session
			if (end_req && !checked) begin
				if (ld_cnt != TOTAL)
					protocol_fault($sformatf("loader accepted %0d words instead of %0d",
						ld_cnt, TOTAL));
				if (rd_cnt != TOTAL)
					protocol_fault($sformatf("reader sent %0d words instead of %0d",
						rd_cnt, TOTAL));
				check_value("done_led", 32'd1, 32'(done_led));
				check_value("hex0", 32'(hex_glyph(4'(link_pkg::DONE))), 32'(hex0));
				check_value("hex1", 32'(hex_glyph(4'(TOTAL % 16))), 32'(hex1));
				check_value("hex2", 32'(hex_glyph(4'(TOTAL % 16))), 32'(hex2));
				checked = 1'b1;
			end
		end

		p_host_req  = host_req;
		p_load_ack  = load_ack;
		p_fpga_req  = fpga_req;
		p_host_ack  = host_ack;
		p_fpga_data = fpga_data;
	end

endmodule

`default_nettype wire

/* testbench/tb_image_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_cfg.svh"

////////////////////////////////////////////////////////////////////////////
// Image buffer testbench
// Shuffled load of the whole buffer, then readback with random ack delays
////////////////////////////////////////////////////////////////////////////

module tb_image_seq;

	localparam int     NUM_WORDS      = `IMG_BANKS * `IMG_DEPTH;
	localparam int     CLK_PERIOD     = 40;
	localparam int     RST_CYCLES     = 3;
	localparam int     ACK_DELAY_MAX  = 7;
	// Budget per word per link
	localparam int     WORD_CYCLES    = 20;
	localparam longint WATCHDOG_NS    = NUM_WORDS * 2 * WORD_CYCLES * CLK_PERIOD;

	logic                 CLOCK_50;
	logic                 rst;
	logic                 host_req;
	link_pkg::host_word_t host_data;
	logic                 load_ack;
	logic                 fpga_req;
	link_pkg::host_word_t fpga_data;
	logic                 host_ack;
	logic [6:0]           hex0;
	logic [6:0]           hex1;
	logic [6:0]           hex2;
	logic                 done_led;
	logic                 end_req;
	logic                 checked;
	int                   val_errs;
	int                   proto_errs;
	integer               seed;

	// Stimulus in load order, expected pixels by location
	link_pkg::host_word_t stim [NUM_WORDS];
	img_pkg::pix_pair_t   exp_pix [NUM_WORDS];

	image_seq_top u_dut (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.host_req (host_req),
		.host_data(host_data),
		.load_ack (load_ack),
		.fpga_req (fpga_req),
		.fpga_data(fpga_data),
		.host_ack (host_ack),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2),
		.done_led (done_led)
	);

	image_checker u_chk (
		.CLOCK_50  (CLOCK_50),
		.rst       (rst),
		.host_req  (host_req),
		.load_ack  (load_ack),
		.fpga_req  (fpga_req),
		.fpga_data (fpga_data),
		.host_ack  (host_ack),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.done_led  (done_led),
		.exp_pix   (exp_pix),
		.end_req   (end_req),
		.val_errs  (val_errs),
		.proto_errs(proto_errs),
		.checked   (checked)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
	end

	// Shuffled locations, random pixel pair for each
	task automatic build_table();
		int          loc [NUM_WORDS];
		int          j;
		int          tmp;
		logic [31:0] rnd;
		for (int i = 0; i < NUM_WORDS; i++) loc[i] = i;
		for (int i = NUM_WORDS - 1; i > 0; i--) begin
			j      = int'($unsigned($random(seed)) % (i + 1));
			tmp    = loc[i];
			loc[i] = loc[j];
			loc[j] = tmp;
		end
		for (int i = 0; i < NUM_WORDS; i++) begin
			rnd           = $random(seed);
			stim[i].bank  = img_pkg::bank_idx_t'(loc[i] / `IMG_DEPTH);
			stim[i].addr  = img_pkg::word_addr_t'(loc[i] % `IMG_DEPTH);
			stim[i].pad   = '0;
			stim[i].pix   = rnd[2*`IMG_PIX_W-1:0];
			exp_pix[loc[i]] = stim[i].pix;
		end
	endtask

	// Host side of the load link
	task automatic load_words();
		for (int i = 0; i < NUM_WORDS; i++) begin
			@(posedge CLOCK_50);
			host_data <= stim[i];
			host_req  <= 1'b1;
			do @(posedge CLOCK_50); while (!load_ack);
			host_req <= 1'b0;
			do @(posedge CLOCK_50); while (load_ack);
		end
	endtask

	// Host side of the read link, random ack delay
	task automatic answer_reads();
		int delay;
		for (int i = 0; i < NUM_WORDS; i++) begin
			do @(posedge CLOCK_50); while (!fpga_req);
			delay = int'($unsigned($random(seed)) % (ACK_DELAY_MAX + 1));
			repeat (delay) @(posedge CLOCK_50);
			host_ack <= 1'b1;
			do @(posedge CLOCK_50); while (fpga_req);
			host_ack <= 1'b0;
		end
	endtask

	initial begin
		seed      = 32'h8c8e;
		rst       = 1'b1;
		host_req  = 1'b0;
		host_data = '0;
		host_ack  = 1'b0;
		end_req   = 1'b0;
		build_table();
		repeat (RST_CYCLES) @(posedge CLOCK_50);
		rst <= 1'b0;
		fork
			load_words();
			answer_reads();
		join
		do @(posedge CLOCK_50); while (!done_led);
		@(posedge CLOCK_50);
		end_req <= 1'b1;
		do @(posedge CLOCK_50); while (!checked);
		$display("Error counts: %0d value, %0d protocol", val_errs, proto_errs);
		if (val_errs + proto_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the session never finished", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/img_pkg.sv
common/link_pkg.sv
verilog/image_bank.sv
loader/frame_loader.sv
reader/frame_reader.sv
verilog/session_ctrl.sv
verilog/image_seq_top.sv
testbench/image_checker.sv
testbench/tb_image_seq.sv

/* Makefile */
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_image_seq
DUT_TOP    = image_seq_top
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
